//--- build.f
cache_sub_pkg.sv
hwpf_stride_engine.sv
hwpf_stride_wrapper.sv
mem_req_arbiter.sv
cache_req_subsystem.sv
tb_cache_req_subsystem.sv

//--- cache_req_subsystem.sv
/*
 * cache request subsystem top
 * load/store/prefetch arbitration onto the memory port,
 * stride prefetchers fed by demand snoops, flush acknowledge
 */
`timescale 1ns/1ps
`default_nettype none

module cache_req_subsystem import cache_sub_pkg::*; (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,

  input  wire logic                            load_valid_i,
  input  wire addr_t                           load_addr_i,
  output      logic                            load_ready_o,
  input  wire logic                            store_valid_i,
  input  wire addr_t                           store_addr_i,
  output      logic                            store_ready_o,

  output      logic                            mem_req_valid_o,
  output      mem_req_t                        mem_req_o,
  input  wire logic                            mem_req_ready_i,

  input  wire logic           [NUM_HWPF-1:0]   hwpf_base_set_i,
  input  wire hwpf_base_t     [NUM_HWPF-1:0]   hwpf_base_i,
  output      hwpf_base_t     [NUM_HWPF-1:0]   hwpf_base_o,
  input  wire logic           [NUM_HWPF-1:0]   hwpf_param_set_i,
  input  wire hwpf_param_t    [NUM_HWPF-1:0]   hwpf_param_i,
  output      hwpf_param_t    [NUM_HWPF-1:0]   hwpf_param_o,
  input  wire logic           [NUM_HWPF-1:0]   hwpf_throttle_set_i,
  input  wire hwpf_throttle_t [NUM_HWPF-1:0]   hwpf_throttle_i,
  output      hwpf_throttle_t [NUM_HWPF-1:0]   hwpf_throttle_o,
  output      hwpf_status_t                    hwpf_status_o,

  input  wire logic                            dcache_flush_i,
  output      logic                            dcache_flush_ack_o
);

  logic                  pf_valid;
  logic                  pf_ready;
  addr_t                 pf_addr;
  logic  [NUM_SNOOP-1:0] snoop_valid;
  addr_t [NUM_SNOOP-1:0] snoop_addr;

  mem_req_arbiter u_arbiter (
    .load_valid_i    (load_valid_i),
    .load_addr_i     (load_addr_i),
    .load_ready_o    (load_ready_o),
    .store_valid_i   (store_valid_i),
    .store_addr_i    (store_addr_i),
    .store_ready_o   (store_ready_o),
    .pf_valid_i      (pf_valid),
    .pf_addr_i       (pf_addr),
    .pf_ready_o      (pf_ready),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .snoop_valid_o   (snoop_valid),
    .snoop_addr_o    (snoop_addr)
  );

  hwpf_stride_wrapper u_hwpf (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .base_set_i     (hwpf_base_set_i),
    .base_i         (hwpf_base_i),
    .base_o         (hwpf_base_o),
    .param_set_i    (hwpf_param_set_i),
    .param_i        (hwpf_param_i),
    .param_o        (hwpf_param_o),
    .throttle_set_i (hwpf_throttle_set_i),
    .throttle_i     (hwpf_throttle_i),
    .throttle_o     (hwpf_throttle_o),
    .status_o       (hwpf_status_o),
    .snoop_valid_i  (snoop_valid),
    .snoop_addr_i   (snoop_addr),
    .pf_valid_o     (pf_valid),
    .pf_addr_o      (pf_addr),
    .pf_ready_i     (pf_ready)
  );

  // nothing to flush, ack the level request on alternate cycles
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dcache_flush_ack_o <= 1'b0;
    end else begin
      dcache_flush_ack_o <= ~dcache_flush_ack_o & dcache_flush_i;
    end
  end

endmodule

`default_nettype wire

//--- cache_sub_pkg.sv
/*
 * cache request subsystem package
 * widths, counts, requester ids and the shared request,
 * prefetcher config and state types
 */
`default_nettype none

package cache_sub_pkg;

  // widths and counts
  localparam int ADDR_W    = 32;
  localparam int NUM_HWPF  = 2;  // stride engines
  localparam int NUM_SNOOP = 2;  // load and store ports
  localparam int STRIDE_W  = 16;
  localparam int NBLK_W    = 8;
  localparam int NWAIT_W   = 8;
  localparam int SID_W     = 2;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [SID_W-1:0]    sid_t;
  typedef logic [STRIDE_W-1:0] stride_t;  // unsigned byte stride
  typedef logic [NBLK_W-1:0]   nblk_t;
  typedef logic [NWAIT_W-1:0]  nwait_t;

  // requester ids on the memory port
  localparam sid_t SID_LOAD  = 2'd0;
  localparam sid_t SID_STORE = 2'd1;
  localparam sid_t SID_PF    = 2'd2;

  // tagged memory request
  typedef struct packed {
    addr_t addr;
    sid_t  sid;
  } mem_req_t;

  typedef struct packed {
    addr_t addr;    // trigger address
    logic  enable;
  } hwpf_base_t;

  typedef struct packed {
    stride_t stride;
    nblk_t   nblocks;  // prefetches per trigger
  } hwpf_param_t;

  typedef struct packed {
    nwait_t nwait;  // idle cycles between prefetches
  } hwpf_throttle_t;

  typedef logic [NUM_HWPF-1:0] hwpf_status_t;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT
  } hwpf_state_e;

endpackage

`default_nettype wire

//--- hwpf_stride_engine.sv
/*
 * stride prefetch engine
 * holds base, param and throttle registers; on a snooped hit on the
 * base it issues nblocks requests at base+k*stride, spaced by nwait
 * idle cycles, then moves the base to the last prefetched address
 */
`timescale 1ns/1ps
`default_nettype none

module hwpf_stride_engine import cache_sub_pkg::*; (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,

  input  wire logic                    base_set_i,
  input  wire hwpf_base_t              base_i,
  output      hwpf_base_t              base_o,
  input  wire logic                    param_set_i,
  input  wire hwpf_param_t             param_i,
  output      hwpf_param_t             param_o,
  input  wire logic                    throttle_set_i,
  input  wire hwpf_throttle_t          throttle_i,
  output      hwpf_throttle_t          throttle_o,
  output      logic                    busy_o,

  input  wire logic  [NUM_SNOOP-1:0]   snoop_valid_i,
  input  wire addr_t [NUM_SNOOP-1:0]   snoop_addr_i,

  output      logic                    req_valid_o,
  output      addr_t                   req_addr_o,
  input  wire logic                    req_ready_i
);

  hwpf_base_t     base_q;
  hwpf_param_t    param_q;
  hwpf_throttle_t throttle_q;

  hwpf_state_e    state_q;
  addr_t          addr_q;   // next prefetch address
  nblk_t          cnt_q;    // prefetches left in this burst
  nwait_t         wait_q;

  addr_t          stride_ext;
  logic           snoop_hit;
  logic           trigger;

  assign stride_ext = addr_t'(param_q.stride);  // zero extended, wraps mod 2^32

  // any snooped demand access on the base address
  always_comb begin
    snoop_hit = 1'b0;
    for (int i = 0; i < NUM_SNOOP; i++) begin
      if (snoop_valid_i[i] && (snoop_addr_i[i] == base_q.addr)) begin
        snoop_hit = 1'b1;
      end
    end
  end

  assign trigger = base_q.enable && (param_q.nblocks != '0) && snoop_hit;

  // param and throttle only change on a software write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      param_q    <= '0;
      throttle_q <= '0;
    end else begin
      if (param_set_i) param_q <= param_i;
      if (throttle_set_i) throttle_q <= throttle_i;
    end
  end

  // base register and burst FSM
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q  <= '0;
      state_q <= IDLE;
      addr_q  <= '0;
      cnt_q   <= '0;
      wait_q  <= '0;
    end else if (base_set_i) begin
      base_q  <= base_i;
      state_q <= IDLE;  // new base aborts a running burst
    end else begin
      unique case (state_q)
        IDLE: begin
          if (trigger) begin
            state_q <= ISSUE;
            addr_q  <= base_q.addr + stride_ext;
            cnt_q   <= param_q.nblocks;
          end
        end
        ISSUE: begin
          if (req_ready_i) begin
            cnt_q  <= cnt_q - nblk_t'(1);
            addr_q <= addr_q + stride_ext;
            if (cnt_q == nblk_t'(1)) begin
              // last one, re-arm on the address just fetched
              base_q.addr <= addr_q;
              state_q     <= IDLE;
            end else if (throttle_q.nwait != '0) begin
              wait_q  <= throttle_q.nwait;
              state_q <= WAIT;
            end
          end
        end
        WAIT: begin
          wait_q <= wait_q - nwait_t'(1);
          if (wait_q == nwait_t'(1)) state_q <= ISSUE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign req_valid_o = (state_q == ISSUE);
  assign req_addr_o  = addr_q;
  assign busy_o      = (state_q != IDLE);

  assign base_o     = base_q;
  assign param_o    = param_q;
  assign throttle_o = throttle_q;

endmodule

`default_nettype wire

//--- hwpf_stride_wrapper.sv
/*
 * stride prefetcher wrapper
 * NUM_HWPF engines, lowest pending index wins the prefetch port,
 * busy bits gathered into the status vector
 */
`timescale 1ns/1ps
`default_nettype none

module hwpf_stride_wrapper import cache_sub_pkg::*; (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,

  input  wire logic           [NUM_HWPF-1:0]   base_set_i,
  input  wire hwpf_base_t     [NUM_HWPF-1:0]   base_i,
  output      hwpf_base_t     [NUM_HWPF-1:0]   base_o,
  input  wire logic           [NUM_HWPF-1:0]   param_set_i,
  input  wire hwpf_param_t    [NUM_HWPF-1:0]   param_i,
  output      hwpf_param_t    [NUM_HWPF-1:0]   param_o,
  input  wire logic           [NUM_HWPF-1:0]   throttle_set_i,
  input  wire hwpf_throttle_t [NUM_HWPF-1:0]   throttle_i,
  output      hwpf_throttle_t [NUM_HWPF-1:0]   throttle_o,
  output      hwpf_status_t                    status_o,

  input  wire logic           [NUM_SNOOP-1:0]  snoop_valid_i,
  input  wire addr_t          [NUM_SNOOP-1:0]  snoop_addr_i,

  output      logic                            pf_valid_o,
  output      addr_t                           pf_addr_o,
  input  wire logic                            pf_ready_i
);

  logic  [NUM_HWPF-1:0] req_valid;
  logic  [NUM_HWPF-1:0] req_ready;
  logic  [NUM_HWPF-1:0] grant;  // one-hot
  addr_t [NUM_HWPF-1:0] req_addr;

  for (genvar h = 0; h < NUM_HWPF; h++) begin : g_engine
    hwpf_stride_engine u_engine (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .base_set_i     (base_set_i[h]),
      .base_i         (base_i[h]),
      .base_o         (base_o[h]),
      .param_set_i    (param_set_i[h]),
      .param_i        (param_i[h]),
      .param_o        (param_o[h]),
      .throttle_set_i (throttle_set_i[h]),
      .throttle_i     (throttle_i[h]),
      .throttle_o     (throttle_o[h]),
      .busy_o         (status_o[h]),
      .snoop_valid_i  (snoop_valid_i),
      .snoop_addr_i   (snoop_addr_i),
      .req_valid_o    (req_valid[h]),
      .req_addr_o     (req_addr[h]),
      .req_ready_i    (req_ready[h])
    );
  end

  // lowest pending engine index takes the port
  always_comb begin
    grant      = '0;
    pf_valid_o = 1'b0;
    pf_addr_o  = req_addr[0];
    for (int i = 0; i < NUM_HWPF; i++) begin
      if (req_valid[i] && !pf_valid_o) begin
        grant[i]   = 1'b1;
        pf_valid_o = 1'b1;
        pf_addr_o  = req_addr[i];
      end
    end
  end

  assign req_ready = grant & {NUM_HWPF{pf_ready_i}};

endmodule

`default_nettype wire

//--- mem_req_arbiter.sv
/*
 * memory request arbiter
 * fixed priority load > store > prefetch onto one valid/ready port,
 * tags the sid and reports demand handshakes as snoops
 */
`timescale 1ns/1ps
`default_nettype none

module mem_req_arbiter import cache_sub_pkg::*; (
  input  wire logic                   load_valid_i,
  input  wire addr_t                  load_addr_i,
  output      logic                   load_ready_o,

  input  wire logic                   store_valid_i,
  input  wire addr_t                  store_addr_i,
  output      logic                   store_ready_o,

  input  wire logic                   pf_valid_i,
  input  wire addr_t                  pf_addr_i,
  output      logic                   pf_ready_o,

  output      logic                   mem_req_valid_o,
  output      mem_req_t               mem_req_o,
  input  wire logic                   mem_req_ready_i,

  output      logic  [NUM_SNOOP-1:0]  snoop_valid_o,
  output      addr_t [NUM_SNOOP-1:0]  snoop_addr_o
);

  // ready goes to whoever holds priority
  assign load_ready_o  = mem_req_ready_i;
  assign store_ready_o = mem_req_ready_i & ~load_valid_i;
  assign pf_ready_o    = mem_req_ready_i & ~load_valid_i & ~store_valid_i;

  assign mem_req_valid_o = load_valid_i | store_valid_i | pf_valid_i;

  always_comb begin
    if (load_valid_i) begin
      mem_req_o.addr = load_addr_i;
      mem_req_o.sid  = SID_LOAD;
    end else if (store_valid_i) begin
      mem_req_o.addr = store_addr_i;
      mem_req_o.sid  = SID_STORE;
    end else begin
      mem_req_o.addr = pf_addr_i;  // also the idle value
      mem_req_o.sid  = SID_PF;
    end
  end

  // demand handshakes only, prefetches never snooped
  assign snoop_valid_o[0] = load_valid_i & load_ready_o;
  assign snoop_addr_o[0]  = load_addr_i;
  assign snoop_valid_o[1] = store_valid_i & store_ready_o;
  assign snoop_addr_o[1]  = store_addr_i;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f build.f --top-module tb_cache_req_subsystem -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
  exit 0
else
  exit 1
fi

//--- tb_cache_req_subsystem.sv
/*
 * random testbench for the cache request subsystem
 * demand traffic, stride prefetch model with per-engine address queues,
 * throttle spacing and flush acknowledge checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_req_subsystem import cache_sub_pkg::*; ();

  localparam int CFG_LEN   = 40;
  localparam int DEM_LEN   = 400;
  localparam int PF_LEN    = 300;
  localparam int GAP_LEN   = 300;
  localparam int FLUSH_LEN = 30;
  localparam int MIX_LEN   = 2000;
  localparam int LIMIT = 2 * (CFG_LEN + DEM_LEN + PF_LEN + GAP_LEN + FLUSH_LEN + MIX_LEN) + 1000;

  logic clk_i;
  logic rst_ni;
  logic load_valid_i, store_valid_i, mem_req_ready_i, dcache_flush_i;
  addr_t load_addr_i, store_addr_i;
  logic load_ready_o, store_ready_o, mem_req_valid_o, dcache_flush_ack_o;
  mem_req_t mem_req_o;
  logic [NUM_HWPF-1:0] hwpf_base_set_i, hwpf_param_set_i, hwpf_throttle_set_i;
  hwpf_base_t [NUM_HWPF-1:0] hwpf_base_i, hwpf_base_o;
  hwpf_param_t [NUM_HWPF-1:0] hwpf_param_i, hwpf_param_o;
  hwpf_throttle_t [NUM_HWPF-1:0] hwpf_throttle_i, hwpf_throttle_o;
  hwpf_status_t hwpf_status_o;

  // reference model state
  hwpf_base_t     m_base [NUM_HWPF];
  hwpf_param_t    m_param [NUM_HWPF];
  hwpf_throttle_t m_throttle [NUM_HWPF];
  hwpf_status_t   m_busy;
  logic           m_first [NUM_HWPF];
  int             m_last [NUM_HWPF];
  addr_t          exp_q [NUM_HWPF][$];
  int             flush_run;
  logic           gap_check;
  int             cycles;
  int             ncnt;

  cache_req_subsystem DUT (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", LIMIT);
      $display("Test failed");
      $fatal(1);
    end
  end

  task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("FAILED %s got %h expected %h", name, got, exp);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) fail_value(name, 64'(got), 64'(exp));
  endtask
  task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp);
    if (got !== exp) fail_value(name, 64'(got), 64'(exp));
  endtask
  task automatic check_base(input string name, input hwpf_base_t got, input hwpf_base_t exp);
    if (got !== exp) fail_value(name, 64'(got), 64'(exp));
  endtask
  task automatic check_param(input string name, input hwpf_param_t got, input hwpf_param_t exp);
    if (got !== exp) fail_value(name, 64'(got), 64'(exp));
  endtask
  task automatic check_throttle(input string name, input hwpf_throttle_t got,
                                input hwpf_throttle_t exp);
    if (got !== exp) fail_value(name, 64'(got), 64'(exp));
  endtask
  task automatic check_status(input string name, input hwpf_status_t got,
                              input hwpf_status_t exp);
    if (got !== exp) fail_value(name, 64'(got), 64'(exp));
  endtask
  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_value(name, 64'(got), 64'(exp));
  endtask

  function automatic mem_req_t make_req(input addr_t a, input sid_t s);
    mem_req_t r;
    r.addr = a;
    r.sid  = s;
    return r;
  endfunction

  // edges seen with the flush request held, ack expected on odd counts
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) flush_run <= 0;
    else if (dcache_flush_i) flush_run <= flush_run + 1;
    else flush_run <= 0;
  end

  // monitor and model, sampled mid-cycle
  always @(negedge clk_i) begin
    logic lfire, sfire, found;
    int   hit;
    if (rst_ni) begin
      ncnt = ncnt + 1;
      check_bit("dcache_flush_ack_o", dcache_flush_ack_o, flush_run[0]);
      check_status("hwpf_status_o", hwpf_status_o, m_busy);
      check_bit("load_ready_o", load_ready_o, mem_req_ready_i);
      check_bit("store_ready_o", store_ready_o, mem_req_ready_i & ~load_valid_i);
      if (load_valid_i) check_req("mem_req_o", mem_req_o, make_req(load_addr_i, SID_LOAD));
      else if (store_valid_i) check_req("mem_req_o", mem_req_o, make_req(store_addr_i, SID_STORE));
      if (load_valid_i || store_valid_i) check_bit("mem_req_valid_o", mem_req_valid_o, 1'b1);
      else if (m_busy == '0) check_bit("mem_req_valid_o", mem_req_valid_o, 1'b0);
      lfire = load_valid_i & mem_req_ready_i;
      sfire = store_valid_i & mem_req_ready_i & ~load_valid_i;
      for (int h = 0; h < NUM_HWPF; h++) begin
        if (!m_busy[h] && m_base[h].enable && m_param[h].nblocks != '0 &&
            ((lfire && load_addr_i == m_base[h].addr) ||
             (sfire && store_addr_i == m_base[h].addr))) begin
          for (int k = 1; k <= int'(m_param[h].nblocks); k++) begin
            exp_q[h].push_back(m_base[h].addr + addr_t'(k) * addr_t'(m_param[h].stride));
          end
          m_busy[h]  = 1'b1;
          m_first[h] = 1'b1;
        end
      end
      if (mem_req_valid_o && mem_req_ready_i && mem_req_o.sid == SID_PF) begin
        found = 1'b0;
        hit   = 0;
        for (int h = 0; h < NUM_HWPF; h++) begin
          if (!found && exp_q[h].size() > 0 && exp_q[h][0] == mem_req_o.addr) begin
            found = 1'b1;
            hit   = h;
          end
        end
        if (!found) begin
          $display("prefetch request to %h matches no expected address", mem_req_o.addr);
          $display("Test failed");
          $fatal(1);
        end else begin
          void'(exp_q[hit].pop_front());
          if (gap_check && !m_first[hit]) begin
            check_addr("prefetch gap", addr_t'(ncnt - m_last[hit]),
                       addr_t'(int'(m_throttle[hit].nwait) + 1));
          end
          m_first[hit] = 1'b0;
          m_last[hit]  = ncnt;
          if (exp_q[hit].size() == 0) begin
            m_busy[hit]      = 1'b0;
            m_base[hit].addr = mem_req_o.addr;  // re-arms on the last address
          end
        end
      end
    end
  end

  function automatic addr_t pick_addr();
    int r;
    r = int'($urandom % 4);
    if (r == 0) return m_base[0].addr;
    if (r == 1) return m_base[1].addr;
    return addr_t'($urandom);
  endfunction

  task automatic write_cfg(input int h, input hwpf_base_t b, input hwpf_param_t p,
                           input hwpf_throttle_t t);
    @(posedge clk_i);
    hwpf_base_set_i[h]     <= 1'b1;
    hwpf_param_set_i[h]    <= 1'b1;
    hwpf_throttle_set_i[h] <= 1'b1;
    hwpf_base_i[h]         <= b;
    hwpf_param_i[h]        <= p;
    hwpf_throttle_i[h]     <= t;
    @(posedge clk_i);
    hwpf_base_set_i     <= '0;
    hwpf_param_set_i    <= '0;
    hwpf_throttle_set_i <= '0;
    m_base[h]     = b;
    m_param[h]    = p;
    m_throttle[h] = t;
    @(negedge clk_i);
    check_base("hwpf_base_o", hwpf_base_o[h], b);
    check_param("hwpf_param_o", hwpf_param_o[h], p);
    check_throttle("hwpf_throttle_o", hwpf_throttle_o[h], t);
  endtask

  task automatic random_cfg(input int h, input logic en);
    hwpf_base_t b;
    hwpf_param_t p;
    hwpf_throttle_t t;
    b.addr    = addr_t'($urandom);
    b.enable  = en;
    p.stride  = stride_t'($urandom);
    p.nblocks = nblk_t'(1 + $urandom % 6);
    t.nwait   = nwait_t'($urandom % 4);
    write_cfg(h, b, p, t);
  endtask

  // random demand traffic with each request held until its handshake
  task automatic traffic(input int len, input int rate, input logic rand_ready);
    logic lf, sf;
    for (int n = 0; n < len; n++) begin
      @(negedge clk_i);
      lf = load_valid_i & mem_req_ready_i;
      sf = store_valid_i & store_ready_o;
      @(posedge clk_i);
      if (!load_valid_i || lf) begin
        load_valid_i <= (int'($urandom % 100) < rate);
        load_addr_i  <= pick_addr();
      end
      if (!store_valid_i || sf) begin
        store_valid_i <= (int'($urandom % 100) < rate);
        store_addr_i  <= pick_addr();
      end
      mem_req_ready_i <= rand_ready ? logic'($urandom % 2) : 1'b1;
    end
    @(posedge clk_i);
    mem_req_ready_i <= 1'b1;
    while (load_valid_i || store_valid_i) begin
      @(negedge clk_i);
      lf = load_valid_i & mem_req_ready_i;
      sf = store_valid_i & store_ready_o;
      @(posedge clk_i);
      if (lf) load_valid_i <= 1'b0;
      if (sf) store_valid_i <= 1'b0;
    end
  endtask

  task automatic wait_idle();
    @(posedge clk_i);
    mem_req_ready_i <= 1'b1;
    do @(negedge clk_i);
    while (hwpf_status_o != '0 || exp_q[0].size() != 0 || exp_q[1].size() != 0);
    for (int h = 0; h < NUM_HWPF; h++) begin
      check_base("hwpf_base_o", hwpf_base_o[h], m_base[h]);
    end
  endtask

  initial begin
    hwpf_base_t b;
    void'($urandom(32'h4deb));
    clk_i = 1'b0;
    rst_ni <= 1'b0;
    load_valid_i <= 1'b0;
    store_valid_i <= 1'b0;
    load_addr_i <= '0;
    store_addr_i <= '0;
    mem_req_ready_i <= 1'b0;
    dcache_flush_i <= 1'b0;
    hwpf_base_set_i <= '0;
    hwpf_param_set_i <= '0;
    hwpf_throttle_set_i <= '0;
    hwpf_base_i <= '0;
    hwpf_param_i <= '0;
    hwpf_throttle_i <= '0;
    gap_check = 1'b0;
    cycles = 0;
    ncnt = 0;
    m_busy = '0;
    for (int h = 0; h < NUM_HWPF; h++) begin
      m_base[h] = '0;
      m_param[h] = '0;
      m_throttle[h] = '0;
      m_first[h] = 1'b0;
      m_last[h] = 0;
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_bit("mem_req_valid_o", mem_req_valid_o, 1'b0);
    for (int h = 0; h < NUM_HWPF; h++) begin
      check_base("hwpf_base_o", hwpf_base_o[h], '0);
      check_param("hwpf_param_o", hwpf_param_o[h], '0);
      check_throttle("hwpf_throttle_o", hwpf_throttle_o[h], '0);
    end
    for (int i = 0; i < 4; i++) random_cfg(i % NUM_HWPF, 1'b0);

    traffic(DEM_LEN, 60, 1'b1);  // engines disabled so only priority and sid matter

    // one engine enabled and the other disabled on the same base
    for (int i = 0; i < 6; i++) begin
      random_cfg(0, 1'b1);
      b = m_base[0];
      b.enable = 1'b0;
      write_cfg(1, b, m_param[0], m_throttle[0]);
      traffic(20, 30, 1'b1);
      wait_idle();
    end

    // throttle spacing with no demand traffic
    gap_check = 1'b1;
    for (int i = 0; i < 6; i++) begin
      random_cfg(0, 1'b1);
      @(posedge clk_i);
      load_valid_i <= 1'b1;
      load_addr_i  <= m_base[0].addr;
      @(posedge clk_i);
      load_valid_i <= 1'b0;
      wait_idle();
    end
    gap_check = 1'b0;

    for (int i = 0; i < 3; i++) begin
      @(posedge clk_i);
      dcache_flush_i <= 1'b1;
      repeat (int'(2 + $urandom % 6)) @(posedge clk_i);
      dcache_flush_i <= 1'b0;
      repeat (2) @(posedge clk_i);
    end

    random_cfg(0, 1'b1);
    random_cfg(1, 1'b1);
    traffic(MIX_LEN, 15, 1'b1);
    wait_idle();

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire
